// ==== sw_pkg.sv ====
package sw_pkg;

    // score arithmetic
    localparam int score_w = 10;

    typedef logic signed [score_w-1:0] score_t;

    // 2-bit nucleotide code
    typedef logic [1:0] base_t;

    localparam score_t match_score    = 10'sd1;
    localparam score_t mismatch_score = -10'sd4;
    localparam score_t gap_open       = -10'sd6;
    localparam score_t gap_extend     = -10'sd1;

    // clears the running best before a scan
    localparam score_t score_min = {1'b1, {(score_w-1){1'b0}}};

    typedef enum logic [2:0] {
        st_idle,
        st_load,
        st_calc,
        st_select,
        st_done
    } ctrl_state_t;

endpackage

// ==== sw_pe.sv ====
module sw_pe #(
    parameter int max_len = 16
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        i_clear,
    input  logic                        i_step,
    input  logic                        i_read_valid,
    input  sw_pkg::base_t               i_read_base,
    input  logic                        i_ref_valid,
    input  sw_pkg::base_t               i_ref_base,
    input  sw_pkg::score_t              i_h_top,
    input  sw_pkg::score_t              i_i_top,
    input  sw_pkg::score_t              i_h_diag,
    output sw_pkg::score_t              o_h,
    output sw_pkg::score_t              o_i,
    output sw_pkg::score_t              o_h_prev,
    output logic                        o_read_valid,
    output sw_pkg::base_t               o_read_base,
    output sw_pkg::score_t              o_row_best,
    output logic [$clog2(max_len)-1:0]  o_row_col
);
    localparam int idx_w = $clog2(max_len);

    // larger of two terms, floored at zero
    function automatic sw_pkg::score_t clamp_max(input sw_pkg::score_t a,
                                                 input sw_pkg::score_t b);
        sw_pkg::score_t m;
        m = (a > b) ? a : b;
        return (m < 0) ? '0 : m;
    endfunction

    sw_pkg::score_t   h_q;
    sw_pkg::score_t   i_q;
    sw_pkg::score_t   d_q;
    sw_pkg::score_t   h_prev_q;
    sw_pkg::score_t   best_q;
    logic [idx_w-1:0] col_q;
    logic [idx_w-1:0] best_col_q;
    logic             read_valid_q;
    sw_pkg::base_t    read_base_q;

    sw_pkg::score_t   sub_sc;
    sw_pkg::score_t   m_sc;
    sw_pkg::score_t   i_sc;
    sw_pkg::score_t   d_sc;
    sw_pkg::score_t   h_sc;
    logic             active;

    assign active = i_step && i_read_valid && i_ref_valid;

    assign sub_sc = (i_read_base == i_ref_base) ? sw_pkg::match_score
                                                : sw_pkg::mismatch_score;
    assign m_sc   = i_h_diag + sub_sc;
    // vertical gap comes from the element above
    assign i_sc   = clamp_max(i_h_top + sw_pkg::gap_open, i_i_top + sw_pkg::gap_extend);
    // horizontal gap from this element's own last cell
    assign d_sc   = clamp_max(h_q + sw_pkg::gap_open, d_q + sw_pkg::gap_extend);
    assign h_sc   = clamp_max(m_sc, (i_sc > d_sc) ? i_sc : d_sc);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            h_q        <= '0;
            i_q        <= '0;
            d_q        <= '0;
            h_prev_q   <= '0;
            col_q      <= '0;
            best_q     <= '0;
            best_col_q <= '0;
        end else if (i_clear) begin
            h_q        <= '0;
            i_q        <= '0;
            d_q        <= '0;
            h_prev_q   <= '0;
            col_q      <= '0;
            best_q     <= '0;
            best_col_q <= '0;
        end else if (active) begin
            h_q      <= h_sc;
            i_q      <= i_sc;
            d_q      <= d_sc;
            h_prev_q <= h_q;
            col_q    <= col_q + 1'b1;
            // first column wins on a tie
            if (h_sc > best_q) begin
                best_q     <= h_sc;
                best_col_q <= col_q;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            read_valid_q <= 1'b0;
        end else if (i_clear) begin
            read_valid_q <= 1'b0;
        end else if (i_step) begin
            read_valid_q <= i_read_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i_step) begin
            read_base_q <= i_read_base;
        end
    end

    assign o_h          = h_q;
    assign o_i          = i_q;
    assign o_h_prev     = h_prev_q;
    assign o_read_valid = read_valid_q;
    assign o_read_base  = read_base_q;
    assign o_row_best   = best_q;
    assign o_row_col    = best_col_q;

endmodule

// ==== sw_array.sv ====
module sw_array #(
    parameter int max_len = 16
) (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic                                      i_accept,
    input  logic                                      i_load,
    input  logic                                      i_calc,
    input  sw_pkg::base_t [max_len-1:0]               i_seq_ref,
    input  sw_pkg::base_t [max_len-1:0]               i_seq_read,
    input  logic [$clog2(max_len):0]                  i_ref_len,
    input  logic [$clog2(max_len):0]                  i_read_len,
    output sw_pkg::score_t [max_len-1:0]              o_row_best,
    output logic [max_len-1:0][$clog2(max_len)-1:0]   o_row_col
);
    localparam int len_w = $clog2(max_len) + 1;

    sw_pkg::base_t [max_len-1:0] ref_q;
    sw_pkg::base_t [max_len-1:0] read_shift;
    logic [len_w-1:0]            ref_len_q;
    logic [len_w-1:0]            read_left;
    logic                        feed_valid;

    // chain links between neighbouring elements
    sw_pkg::score_t pe_h      [max_len];
    sw_pkg::score_t pe_i      [max_len];
    sw_pkg::score_t pe_h_prev [max_len];
    logic           pe_rv     [max_len];
    sw_pkg::base_t  pe_rb     [max_len];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ref_len_q <= '0;
            read_left <= '0;
        end else if (i_accept) begin
            ref_len_q <= i_ref_len;
            read_left <= i_read_len;
        end else if (i_calc && read_left != '0) begin
            read_left <= read_left - 1'b1;
        end
    end

    // base 0 sits in the top slot and leaves first
    always_ff @(posedge clk) begin
        if (i_accept) begin
            ref_q      <= i_seq_ref;
            read_shift <= i_seq_read;
        end else if (i_calc) begin
            read_shift <= read_shift << 2;
        end
    end

    assign feed_valid = (read_left != '0);

    for (genvar g = 0; g < max_len; g++) begin : g_pe
        sw_pkg::score_t h_top;
        sw_pkg::score_t i_top;
        sw_pkg::score_t h_diag;
        logic           rv_in;
        sw_pkg::base_t  rb_in;

        if (g == 0) begin : g_head
            // row 0 sees the zero border above it
            assign h_top  = '0;
            assign i_top  = '0;
            assign h_diag = '0;
            assign rv_in  = feed_valid;
            assign rb_in  = read_shift[max_len-1];
        end else begin : g_link
            assign h_top  = pe_h[g-1];
            assign i_top  = pe_i[g-1];
            assign h_diag = pe_h_prev[g-1];
            assign rv_in  = pe_rv[g-1];
            assign rb_in  = pe_rb[g-1];
        end

        sw_pe #(
            .max_len (max_len)
        ) u_pe (
            .clk          (clk),
            .rst          (rst),
            .i_clear      (i_load),
            .i_step       (i_calc),
            .i_read_valid (rv_in),
            .i_read_base  (rb_in),
            .i_ref_valid  (g < ref_len_q),
            .i_ref_base   (ref_q[max_len-1-g]),
            .i_h_top      (h_top),
            .i_i_top      (i_top),
            .i_h_diag     (h_diag),
            .o_h          (pe_h[g]),
            .o_i          (pe_i[g]),
            .o_h_prev     (pe_h_prev[g]),
            .o_read_valid (pe_rv[g]),
            .o_read_base  (pe_rb[g]),
            .o_row_best   (o_row_best[g]),
            .o_row_col    (o_row_col[g])
        );
    end

endmodule

// ==== sw_ctrl.sv ====
module sw_ctrl #(
    parameter int max_len = 16
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        i_valid,
    input  logic                        i_ready,
    input  logic [$clog2(max_len):0]    i_ref_len,
    input  logic [$clog2(max_len):0]    i_read_len,
    output logic                        o_ready,
    output logic                        o_accept,
    output logic                        o_load,
    output logic                        o_calc,
    output logic                        o_sel,
    output logic                        o_release,
    output logic [$clog2(max_len)-1:0]  o_sel_idx
);
    localparam int len_w = $clog2(max_len) + 1;
    localparam int idx_w = $clog2(max_len);
    localparam int cnt_w = $clog2(2 * max_len) + 1;

    sw_pkg::ctrl_state_t state_q;
    sw_pkg::ctrl_state_t state_d;
    logic [cnt_w-1:0]    cnt_q;
    logic [len_w-1:0]    ref_len_q;
    logic [len_w-1:0]    read_len_q;
    logic [cnt_w-1:0]    calc_last;
    logic [cnt_w-1:0]    sel_last;
    logic                calc_end;
    logic                sel_end;

    // wavefront needs read_len + ref_len - 1 steps
    assign calc_last = cnt_w'(read_len_q) + cnt_w'(ref_len_q) - 1'b1;
    assign sel_last  = cnt_w'(ref_len_q) - 1'b1;
    assign calc_end  = (cnt_q == calc_last);
    assign sel_end   = (cnt_q == sel_last);

    always_comb begin
        state_d = state_q;
        case (state_q)
            sw_pkg::st_idle:   if (o_accept) state_d = sw_pkg::st_load;
            sw_pkg::st_load:   state_d = sw_pkg::st_calc;
            sw_pkg::st_calc:   if (calc_end) state_d = sw_pkg::st_select;
            sw_pkg::st_select: if (sel_end) state_d = sw_pkg::st_done;
            sw_pkg::st_done:   if (i_ready) state_d = sw_pkg::st_idle;
            default:           state_d = sw_pkg::st_idle;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q    <= sw_pkg::st_idle;
            cnt_q      <= '0;
            ref_len_q  <= '0;
            read_len_q <= '0;
        end else begin
            state_q <= state_d;
            if (o_accept) begin
                ref_len_q  <= i_ref_len;
                read_len_q <= i_read_len;
            end
            case (state_q)
                // calculation counts from 1
                sw_pkg::st_load:   cnt_q <= cnt_w'(1);
                sw_pkg::st_calc:   cnt_q <= calc_end ? '0 : cnt_q + 1'b1;
                sw_pkg::st_select: cnt_q <= sel_end ? '0 : cnt_q + 1'b1;
                default:           cnt_q <= '0;
            endcase
        end
    end

    assign o_ready   = (state_q == sw_pkg::st_idle);
    assign o_accept  = o_ready && i_valid;
    assign o_load    = (state_q == sw_pkg::st_load);
    assign o_calc    = (state_q == sw_pkg::st_calc);
    assign o_sel     = (state_q == sw_pkg::st_select);
    assign o_release = (state_q == sw_pkg::st_done) && i_ready;
    assign o_sel_idx = cnt_q[idx_w-1:0];

endmodule

// ==== sw_best_select.sv ====
module sw_best_select #(
    parameter int max_len = 16
) (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic                                      i_load,
    input  logic                                      i_sel,
    input  logic                                      i_release,
    input  logic [$clog2(max_len)-1:0]                i_sel_idx,
    input  sw_pkg::score_t [max_len-1:0]              i_row_best,
    input  logic [max_len-1:0][$clog2(max_len)-1:0]   i_row_col,
    output logic                                      o_valid,
    output sw_pkg::score_t                            o_score,
    output logic [$clog2(max_len)-1:0]                o_row,
    output logic [$clog2(max_len)-1:0]                o_column
);
    localparam int idx_w = $clog2(max_len);

    sw_pkg::score_t   best_q;
    logic [idx_w-1:0] best_row_q;
    logic [idx_w-1:0] best_col_q;
    sw_pkg::score_t   sel_score;
    logic [idx_w-1:0] sel_col;

    assign sel_score = i_row_best[i_sel_idx];
    assign sel_col   = i_row_col[i_sel_idx];

    // rows arrive in ascending order, so strict compare keeps the lowest row
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            best_q     <= sw_pkg::score_min;
            best_row_q <= '0;
            best_col_q <= '0;
        end else if (i_load) begin
            best_q     <= sw_pkg::score_min;
            best_row_q <= '0;
            best_col_q <= '0;
        end else if (i_sel && sel_score > best_q) begin
            best_q     <= sel_score;
            best_row_q <= i_sel_idx;
            best_col_q <= sel_col;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_valid  <= 1'b0;
            o_score  <= '0;
            o_row    <= '0;
            o_column <= '0;
        end else begin
            o_valid <= i_release;
            if (i_release) begin
                o_score  <= best_q;
                o_row    <= best_row_q;
                o_column <= best_col_q;
            end
        end
    end

endmodule

// ==== sw_core.sv ====
module sw_core #(
    parameter int max_len = 16
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          i_valid,
    input  sw_pkg::base_t [max_len-1:0]   i_seq_ref,
    input  sw_pkg::base_t [max_len-1:0]   i_seq_read,
    input  logic [$clog2(max_len):0]      i_ref_len,
    input  logic [$clog2(max_len):0]      i_read_len,
    input  logic                          i_ready,
    output logic                          o_ready,
    output logic                          o_valid,
    output sw_pkg::score_t                o_score,
    output logic [$clog2(max_len)-1:0]    o_row,
    output logic [$clog2(max_len)-1:0]    o_column
);
    localparam int idx_w = $clog2(max_len);

    logic                           accept;
    logic                           load;
    logic                           calc;
    logic                           sel;
    logic                           release_res;
    logic [idx_w-1:0]               sel_idx;
    sw_pkg::score_t [max_len-1:0]   row_best;
    logic [max_len-1:0][idx_w-1:0]  row_col;

    sw_ctrl #(
        .max_len (max_len)
    ) u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .i_valid    (i_valid),
        .i_ready    (i_ready),
        .i_ref_len  (i_ref_len),
        .i_read_len (i_read_len),
        .o_ready    (o_ready),
        .o_accept   (accept),
        .o_load     (load),
        .o_calc     (calc),
        .o_sel      (sel),
        .o_release  (release_res),
        .o_sel_idx  (sel_idx)
    );

    sw_array #(
        .max_len (max_len)
    ) u_array (
        .clk        (clk),
        .rst        (rst),
        .i_accept   (accept),
        .i_load     (load),
        .i_calc     (calc),
        .i_seq_ref  (i_seq_ref),
        .i_seq_read (i_seq_read),
        .i_ref_len  (i_ref_len),
        .i_read_len (i_read_len),
        .o_row_best (row_best),
        .o_row_col  (row_col)
    );

    sw_best_select #(
        .max_len (max_len)
    ) u_best_select (
        .clk        (clk),
        .rst        (rst),
        .i_load     (load),
        .i_sel      (sel),
        .i_release  (release_res),
        .i_sel_idx  (sel_idx),
        .i_row_best (row_best),
        .i_row_col  (row_col),
        .o_valid    (o_valid),
        .o_score    (o_score),
        .o_row      (o_row),
        .o_column   (o_column)
    );

endmodule

// ==== tb_sw_core.sv ====
module tb_sw_core;

    localparam int max_len   = 16;
    localparam int len_w     = $clog2(max_len) + 1;
    localparam int idx_w     = $clog2(max_len);
    localparam int num_tests = 11;
    localparam int words     = 7;

    logic                        clk = 1'b0;
    logic                        rst;
    logic                        i_valid;
    logic                        i_ready;
    sw_pkg::base_t [max_len-1:0] i_seq_ref;
    sw_pkg::base_t [max_len-1:0] i_seq_read;
    logic [len_w-1:0]            i_ref_len;
    logic [len_w-1:0]            i_read_len;
    logic                        o_ready;
    logic                        o_valid;
    sw_pkg::score_t              o_score;
    logic [idx_w-1:0]            o_row;
    logic [idx_w-1:0]            o_column;

    // seven words per test in file column order
    logic [31:0] tv_mem [num_tests*words];
    logic [31:0] lfsr_state;
    int          pulse_count = 0;

    sw_core #(
        .max_len (max_len)
    ) i_dut (
        .clk        (clk),
        .rst        (rst),
        .i_valid    (i_valid),
        .i_seq_ref  (i_seq_ref),
        .i_seq_read (i_seq_read),
        .i_ref_len  (i_ref_len),
        .i_read_len (i_read_len),
        .i_ready    (i_ready),
        .o_ready    (o_ready),
        .o_valid    (o_valid),
        .o_score    (o_score),
        .o_row      (o_row),
        .o_column   (o_column)
    );

    initial begin
        forever #10 clk = ~clk;
    end

    // counts result pulses independently of the test flow
    always @(negedge clk) begin
        if (!rst && o_valid) begin
            pulse_count++;
        end
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "run aborted");
    endtask

    task automatic report_mismatch(input string msg);
        abort_run($sformatf("MISMATCH at time %0t: %s", $time, msg));
    endtask

    task automatic check_score(input sw_pkg::score_t got, input sw_pkg::score_t exp,
                               input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s got %0d expected %0d", what, got, exp));
        end
    endtask

    task automatic check_index(input logic [idx_w-1:0] got, input logic [idx_w-1:0] exp,
                               input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s got %0d expected %0d", what, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s got %b expected %b", what, got, exp));
        end
    endtask

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic draw_bits(input int n, output int value);
        value = 0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = (value << 1) | int'(lfsr_state[0]);
        end
    endtask

    task automatic run_test(input int t);
        int               base;
        int               hold;
        sw_pkg::score_t   exp_score;
        logic [idx_w-1:0] exp_row;
        logic [idx_w-1:0] exp_col;
        base      = t * words;
        exp_score = tv_mem[base+4][sw_pkg::score_w-1:0];
        exp_row   = tv_mem[base+5][idx_w-1:0];
        exp_col   = tv_mem[base+6][idx_w-1:0];
        while (!o_ready) @(negedge clk);
        i_valid    = 1'b1;
        i_ready    = 1'b0;
        i_ref_len  = tv_mem[base][len_w-1:0];
        i_read_len = tv_mem[base+1][len_w-1:0];
        i_seq_ref  = tv_mem[base+2];
        i_seq_read = tv_mem[base+3];
        @(negedge clk);
        i_valid = 1'b0;
        check_flag(o_ready, 1'b0, $sformatf("test %0d o_ready after accept", t));
        // back-pressure before the result may leave
        draw_bits(3, hold);
        repeat (hold) begin
            @(negedge clk);
            check_flag(o_valid, 1'b0, $sformatf("test %0d o_valid while i_ready low", t));
        end
        i_ready = 1'b1;
        @(negedge clk);
        while (!o_valid) @(negedge clk);
        check_score(o_score, exp_score, $sformatf("test %0d score", t));
        check_index(o_row, exp_row, $sformatf("test %0d row", t));
        check_index(o_column, exp_col, $sformatf("test %0d column", t));
        i_ready = 1'b0;
        @(negedge clk);
        check_flag(o_valid, 1'b0, $sformatf("test %0d o_valid width", t));
        check_flag(o_ready, 1'b1, $sformatf("test %0d o_ready after result", t));
        if (pulse_count != t + 1) begin
            report_mismatch($sformatf("test %0d result count %0d", t, pulse_count));
        end
    endtask

    initial begin
        rst        = 1'b1;
        i_valid    = 1'b0;
        i_ready    = 1'b0;
        i_seq_ref  = '0;
        i_seq_read = '0;
        i_ref_len  = '0;
        i_read_len = '0;
        lfsr_state = 32'h84d9;
        $readmemh("sw_core_testdata.txt", tv_mem);
        if ($isunknown(tv_mem[num_tests*words-1])) begin
            abort_run("test data file is missing or too short");
        end
        repeat (4) @(negedge clk);
        rst = 1'b0;
        check_flag(o_ready, 1'b1, "o_ready after reset");
        check_flag(o_valid, 1'b0, "o_valid after reset");
        for (int t = 0; t < num_tests; t++) begin
            run_test(t);
        end
        $display("Simulation completed successfully");
        $finish;
    end

    // watchdog
    initial begin
        repeat (num_tests * 200) @(posedge clk);
        abort_run($sformatf("timeout: tests did not finish within %0d cycles",
                            num_tests * 200));
    end

endmodule

// ==== sw_core_testdata.txt ====
// ref_len read_len ref_seq read_seq score row column
// all hex, base 0 in the top two bits of each sequence
10 10 1b1b1b1b 1b1b1b1b 010 f f
10 10 00000000 ffffffff 000 0 0
// one-base gap in the reference, then in the read
10 f 1b4b4eb1 1b493ac5 009 f e
f 10 1b493ac5 1b4b4eb1 009 e f
// two-base gap ties the plain match, lowest row kept
10 e 1b4bd3ac 1b493aca 007 6 6
// short lengths with matching bases past the end
1 1 00000000 00000000 001 0 0
1 1 40000000 00000000 000 0 0
3 5 8c000000 58c00000 003 2 4
5 2 f1aaaaaa 6aaaaaaa 002 4 1
// ties across rows and within a row
8 3 1bc60000 1bffffff 003 2 2
2 5 18400000 18400000 002 1 1

// ==== sw_core.f ====
sw_pkg.sv
sw_pe.sv
sw_array.sv
sw_ctrl.sv
sw_best_select.sv
sw_core.sv
tb_sw_core.sv
